/* Bender.yml */
package:
  name: fetch_stage

sources:
  - verilog/fetchPkg.sv
  - verilog/instrMem.sv
  - verilog/instrDecoder.sv
  - verilog/hazardUnit.sv
  - verilog/progCounter.sv
  - verilog/fetchStage.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/fetchStageTb.sv

/* filelist.f */
+incdir+verif
verilog/fetchPkg.sv
verilog/instrMem.sv
verilog/instrDecoder.sv
verilog/hazardUnit.sv
verilog/progCounter.sv
verilog/fetchStage.sv
verif/fetchStageTb.sv

/* verif/fetchModel.svh */
// ==============================
// Reference model of the fetch front end, included by the testbench
// Own memory, pc, halt flag and load record, stepped once per cycle
// ==============================
`ifndef FETCH_MODEL_SVH
`define FETCH_MODEL_SVH

word_t    mMem [256];
word_t    mPc;
logic     mHalted;
logic     mRecValid;
regAddr_t mRecReg;
word_t    expInstr;     // Predicted issued word
ctrl_t    expCtrl;
regAddr_t expDest;
logic     expBubble;

// Columns: regWrite memEnable memWr val2Reg aluSel, immSel,
// branch jump regJmp link halt err usesRs usesRt, destSel
function automatic ctrl_t decodeOpcode(input opcode_t op);
    case (op)
        OP_HALT: return ctrl_t'({5'b00000, IMM_I5,  8'b00001000, DEST_RS});
        OP_NOP:  return ctrl_t'({5'b00000, IMM_I5,  8'b00000000, DEST_RS});
        OP_J:    return ctrl_t'({5'b00000, IMM_J11, 8'b01000000, DEST_RS});
        OP_JR:   return ctrl_t'({5'b00000, IMM_B8,  8'b01100010, DEST_RS});
        OP_JAL:  return ctrl_t'({5'b10000, IMM_J11, 8'b01010000, DEST_LINK});
        OP_JALR: return ctrl_t'({5'b10000, IMM_B8,  8'b01110010, DEST_LINK});
        OP_ADDI: return ctrl_t'({5'b10001, IMM_I5,  8'b00000010, DEST_RD_I});
        OP_BEQZ: return ctrl_t'({5'b00000, IMM_B8,  8'b10000010, DEST_RS});
        OP_ST:   return ctrl_t'({5'b01101, IMM_I5,  8'b00000011, DEST_RS});
        OP_LD:   return ctrl_t'({5'b11011, IMM_I5,  8'b00000010, DEST_RD_I});
        OP_LBI:  return ctrl_t'({5'b10001, IMM_LBI, 8'b00000000, DEST_RS});
        OP_ALU:  return ctrl_t'({5'b10000, IMM_I5,  8'b00000011, DEST_RD_R});
        default: return ctrl_t'({5'b00000, IMM_I5,  8'b00000100, DEST_RS});
    endcase
endfunction

function automatic regAddr_t pickDest(input word_t w, input destSel_t sel);
    case (sel)
        DEST_RS:   return w[10:8];
        DEST_RD_R: return w[4:2];
        DEST_LINK: return 3'd7;
        default:   return w[7:5];
    endcase
endfunction

task automatic predictOutputs();
    word_t w;
    ctrl_t fc;
    w  = mMem[mPc[8:1]];     // 256 words, wraps above bit 8
    fc = decodeOpcode(w[15:11]);
    expBubble = mRecValid && ((fc.usesRs && w[10:8] == mRecReg) ||
                              (fc.usesRt && w[7:5] == mRecReg));
    expInstr = expBubble ? NOP_WORD : w;
    expCtrl  = decodeOpcode(expInstr[15:11]);
    expDest  = pickDest(expInstr, expCtrl.destSel);
endtask

task automatic advanceModel(input logic sel, input word_t target, input word_t base);
    opcode_t op;
    logic    wasHalted;
    op        = expInstr[15:11];
    wasHalted = mHalted;
    if (mHalted || expCtrl.halt) begin
        mHalted = 1'b1;
    end else if (sel) begin
        mPc = target;
    end else if (op == OP_J || op == OP_JAL) begin
        mPc = mPc + 16'd2 + {{5{expInstr[10]}}, expInstr[10:0]};
    end else if (op == OP_JR || op == OP_JALR) begin
        mPc = base + {{8{expInstr[7]}}, expInstr[7:0]};
    end else if (!expBubble) begin
        mPc = mPc + 16'd2;
    end
    if (!wasHalted) begin
        mRecValid = expCtrl.memEnable && !expCtrl.memWr && expCtrl.regWrite;
        mRecReg   = expDest;
    end
endtask

`endif

/* verif/fetchStageTb.sv */
// ==============================
// Testbench for the fetch front end
// Six random program tests checked every cycle against the model
// ==============================

module fetchStageTb;
    import fetchPkg::*;

    localparam int imemWords = 256;

    logic        clk;
    logic        rstN;
    logic        pcSel;
    word_t       brnchAddr;
    word_t       rsData;
    logic        imemWe;
    logic [7:0]  imemAddr;
    word_t       imemWdata;
    word_t       pc;
    word_t       instr;
    ctrl_t       ctrl;
    regAddr_t    writeRegAddr;
    logic        halted;

    logic [31:0] lfsr = 32'hb973;
    int          errCount = 0;
    int          checkCount = 0;
    int          testStart = 0;
    int          nopSeen = 0;
    word_t       pcSeen;        // Sampled at the last check
    logic        haltSeen;
    word_t       prog [16];
    // Straight-line ops first, then jumps, NOP and LD
    opcode_t     mixOps [11] = '{OP_ADDI, OP_ALU, OP_LBI, OP_ST, OP_BEQZ,
                                 OP_J, OP_JR, OP_JAL, OP_JALR, OP_NOP, OP_LD};

    `include "fetchModel.svh"

    fetchStage #(.imemWords(imemWords), .resetPc(16'h0000)) dut_i (
        .clk         (clk),
        .rstN        (rstN),
        .pcSel       (pcSel),
        .brnchAddr   (brnchAddr),
        .rsData      (rsData),
        .imemWe      (imemWe),
        .imemAddr    (imemAddr),
        .imemWdata   (imemWdata),
        .pc          (pc),
        .instr       (instr),
        .ctrl        (ctrl),
        .writeRegAddr(writeRegAddr),
        .halted      (halted)
    );

    always #5 clk = ~clk;

    // Galois LFSR, one step per bit
    function automatic logic [15:0] randBits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[14:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha3000000) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic checkVal(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // Drives one cycle, compares at the falling edge
    task automatic runCycle(input logic sel, input word_t target, input word_t base);
        pcSel     <= sel;
        brnchAddr <= target;
        rsData    <= base;
        @(negedge clk);
        predictOutputs();
        checkVal("pc", pc, mPc);
        checkVal("instr", instr, expInstr);
        checkVal("ctrl", ctrl, expCtrl);
        checkVal("writeRegAddr", writeRegAddr, expDest);
        checkVal("halted", halted, mHalted);
        pcSeen   = pc;
        haltSeen = halted;
        if (instr === NOP_WORD) begin
            nopSeen++;
        end
        advanceModel(sel, target, base);
        @(posedge clk);
    endtask

    task automatic resetAndLoad();
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            rstN      <= 1'b0;
            imemWe    <= 1'b1;
            imemAddr  <= 8'(i);
            imemWdata <= prog[i];
            mMem[i]   = prog[i];
        end
        @(posedge clk);
        imemWe    <= 1'b0;
        rstN      <= 1'b1;
        pcSel     <= 1'b0;
        mPc       = 16'h0000;
        mHalted   = 1'b0;
        mRecValid = 1'b0;
        nopSeen   = 0;
    endtask

    task automatic finishTest(input string name);
        $display("Test %s done with %0d errors", name, errCount - testStart);
        testStart = errCount;
    endtask

    initial begin
        word_t   w;
        word_t   c;
        opcode_t op;
        ctrl_t   cc;
        int      depCount;
        int      cycles;
        word_t   holdPc;
        clk       = 1'b0;
        rstN      = 1'b0;
        pcSel     = 1'b0;
        brnchAddr = '0;
        rsData    = '0;
        imemWe    = 1'b0;
        imemAddr  = '0;
        imemWdata = '0;
        // Known code everywhere, so redirects land on ADDI words
        for (int a = 0; a < imemWords; a++) begin
            @(posedge clk);
            imemWe    <= 1'b1;
            imemAddr  <= 8'(a);
            imemWdata <= {OP_ADDI, 3'b000, 8'(a)};
            mMem[a]   = {OP_ADDI, 3'b000, 8'(a)};
        end

        for (int i = 0; i < 16; i++) begin
            prog[i] = {mixOps[randBits(3) % 5], 11'(randBits(11))};
        end
        resetAndLoad();
        repeat (16) runCycle(1'b0, 16'h0, 16'h0);
        finishTest("straight-line");

        depCount = 0;
        for (int i = 0; i < 8; i++) begin
            w  = {OP_LD, 11'(randBits(11))};
            c  = {(randBits(1) != 0) ? OP_ST : OP_ALU, 11'(randBits(11))};
            op = opcode_t'(randBits(2));
            if (op == 0) begin
                c[10:8] = w[7:5];
            end else if (op == 1) begin
                c[7:5] = w[7:5];
            end else begin
                c[10:8] = w[7:5] ^ 3'd1;     // Neither source matches
                c[7:5]  = w[7:5] ^ 3'd2;
            end
            depCount    = depCount + ((op < 2) ? 1 : 0);
            prog[2*i]   = w;
            prog[2*i+1] = c;
        end
        resetAndLoad();
        cycles = 0;
        pcSeen = '0;
        while (pcSeen !== 16'd32 && cycles < 40) begin
            runCycle(1'b0, 16'h0, 16'h0);
            cycles++;
        end
        if (cycles >= 40) begin
            errCount++;
            $display("Timed out waiting for the load-use program to reach pc 0x20");
        end
        if (nopSeen != depCount) begin
            errCount++;
            $display("Saw %0d bubbles for %0d dependent loads", nopSeen, depCount);
        end
        finishTest("load-use");

        for (int i = 0; i < 16; i++) begin
            prog[i] = {mixOps[randBits(4) % 11], 11'(randBits(11))};
        end
        resetAndLoad();
        repeat (40) runCycle(randBits(2) == 0, randBits(16) & 16'hfffe, randBits(16));
        finishTest("redirect");

        for (int i = 0; i < 16; i++) begin
            prog[i] = {mixOps[5 + randBits(2)], 11'(randBits(11))};
        end
        resetAndLoad();
        // Steer back into the program whenever a jump leaves it
        repeat (40) runCycle(mPc > 16'd30, randBits(5) & 16'h1e, randBits(16));
        finishTest("jumps");

        for (int i = 0; i < 16; i++) begin
            prog[i] = {mixOps[randBits(3) % 5], 11'(randBits(11))};
        end
        prog[5] = {OP_HALT, 11'(randBits(11))};
        resetAndLoad();
        cycles   = 0;
        haltSeen = 1'b0;
        while (!haltSeen && cycles < 20) begin
            runCycle(1'b0, 16'h0, 16'h0);
            cycles++;
        end
        if (!haltSeen) begin
            errCount++;
            $display("Timed out waiting for halted to rise");
        end
        holdPc = 16'd10;    // HALT sits at word 5
        repeat (20) begin
            runCycle(randBits(1) != 0, randBits(16) & 16'hfffe, 16'h0);
            checkVal("pc", pcSeen, holdPc);
        end
        finishTest("halt");

        for (int i = 0; i < 16; i++) begin
            do begin
                op = opcode_t'(randBits(5));
                cc = decodeOpcode(op);
            end while (!cc.ctrlErr);
            prog[i] = {op, 11'(randBits(11))};
        end
        resetAndLoad();
        repeat (16) runCycle(1'b0, 16'h0, 16'h0);
        finishTest("illegal-opcode");

        $display("%0d checks, %0d errors", checkCount, errCount);
        if (errCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* verilog/fetchPkg.sv */
// ==============================
// Shared types, opcodes and the control record of the fetch front end
// Imported by the RTL modules and the testbench model
// ==============================

package fetchPkg;

    typedef logic [15:0] word_t;       // Data, instruction and address word
    typedef logic [2:0]  regAddr_t;    // One of eight registers
    typedef logic [4:0]  opcode_t;     // Instruction bits 15:11
    typedef logic [1:0]  destSel_t;    // Destination register select
    typedef logic [2:0]  immSel_t;     // Immediate format for later stages

    // Opcodes
    localparam opcode_t OP_HALT = 5'b00000;
    localparam opcode_t OP_NOP  = 5'b00001;
    localparam opcode_t OP_J    = 5'b00100;
    localparam opcode_t OP_JR   = 5'b00101;
    localparam opcode_t OP_JAL  = 5'b00110;
    localparam opcode_t OP_JALR = 5'b00111;
    localparam opcode_t OP_ADDI = 5'b01000;
    localparam opcode_t OP_BEQZ = 5'b01100;
    localparam opcode_t OP_ST   = 5'b10000;
    localparam opcode_t OP_LD   = 5'b10001;
    localparam opcode_t OP_LBI  = 5'b11000;
    localparam opcode_t OP_ALU  = 5'b11011;

    // Bubble inserted on a load-use stall
    localparam word_t NOP_WORD = 16'h0800;

    // Destination select encodings
    localparam destSel_t DEST_RS   = 2'd0;    // Bits 10:8
    localparam destSel_t DEST_RD_R = 2'd1;    // Bits 4:2
    localparam destSel_t DEST_LINK = 2'd2;    // R7
    localparam destSel_t DEST_RD_I = 2'd3;    // Bits 7:5

    // Immediate formats
    localparam immSel_t IMM_I5  = 3'd0;       // 5-bit signed, I-format
    localparam immSel_t IMM_B8  = 3'd2;       // 8-bit signed, branch and JR
    localparam immSel_t IMM_LBI = 3'd3;       // 8-bit signed load immediate
    localparam immSel_t IMM_J11 = 3'd4;       // 11-bit jump displacement

    // Decoded control record
    typedef struct packed {
        logic     regWrite;
        logic     memEnable;
        logic     memWr;
        logic     val2Reg;      // Write back memory data instead of ALU
        logic     aluSel;       // Second operand is the immediate
        immSel_t  immSel;
        logic     branchFlag;
        logic     jumpFlag;
        logic     regJmp;       // Jump target comes from a register
        logic     linkWrite;    // Writes pc+2 to the link register
        logic     halt;
        logic     ctrlErr;      // Undefined opcode
        logic     usesRs;       // Reads bits 10:8
        logic     usesRt;       // Reads bits 7:5
        destSel_t destSel;
    } ctrl_t;

    // Program counter state machine
    typedef enum logic {
        PC_RUN,
        PC_HALTED
    } pcState_t;

endpackage

/* verilog/fetchStage.sv */
// ==============================
// Fetch and decode front end, top level
// Connects pc, instruction memory, hazard unit and both decoders
// ==============================

module fetchStage #(
    parameter int              imemWords = 256,
    parameter fetchPkg::word_t resetPc   = 16'h0000
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         pcSel,      // Taken branch strobe
    input  fetchPkg::word_t              brnchAddr,
    input  fetchPkg::word_t              rsData,     // Base for JR and JALR
    input  logic                         imemWe,
    input  logic [$clog2(imemWords)-1:0] imemAddr,
    input  fetchPkg::word_t              imemWdata,
    output fetchPkg::word_t              pc,
    output fetchPkg::word_t              instr,      // Issued word
    output fetchPkg::ctrl_t              ctrl,
    output fetchPkg::regAddr_t           writeRegAddr,
    output logic                         halted
);
    import fetchPkg::*;

    word_t fetchWord;
    ctrl_t fetchCtrl;
    logic  bubble;

    progCounter #(.resetPc(resetPc)) pcCnt (
        .clk      (clk),
        .rstN     (rstN),
        .stall    (bubble),
        .pcSel    (pcSel),
        .brnchAddr(brnchAddr),
        .rsData   (rsData),
        .issCtrl  (ctrl),
        .issInstr (instr),
        .pc       (pc),
        .halted   (halted)
    );

    instrMem #(.imemWords(imemWords)) imem (
        .clk  (clk),
        .we   (imemWe),
        .waddr(imemAddr),
        .wdata(imemWdata),
        .raddr(pc),
        .rdata(fetchWord)
    );

    // Raw word, only its source usage is needed
    instrDecoder checkDec (
        .instr   (fetchWord),
        .ctrl    (fetchCtrl),
        .destAddr()
    );

    hazardUnit hdu (
        .clk      (clk),
        .rstN     (rstN),
        .halted   (halted),
        .fetchWord(fetchWord),
        .fetchCtrl(fetchCtrl),
        .issCtrl  (ctrl),
        .issDest  (writeRegAddr),
        .bubble   (bubble)
    );

    assign instr = bubble ? NOP_WORD : fetchWord;   // Bubble replaces the consumer

    instrDecoder issueDec (
        .instr   (instr),
        .ctrl    (ctrl),
        .destAddr(writeRegAddr)
    );

endmodule

/* verilog/hazardUnit.sv */
// ==============================
// Load-use hazard detection
// Tracks the last issued load and flags a consumer in the fetched word
// ==============================

module hazardUnit (
    input  logic               clk,
    input  logic               rstN,
    input  logic               halted,
    input  fetchPkg::word_t    fetchWord,
    input  fetchPkg::ctrl_t    fetchCtrl,
    input  fetchPkg::ctrl_t    issCtrl,
    input  fetchPkg::regAddr_t issDest,
    output logic               bubble
);
    import fetchPkg::*;

    logic     recValid;
    regAddr_t recReg;       // Destination of the last issued load
    logic     issLoad;
    logic     rsHit;
    logic     rtHit;

    assign issLoad = issCtrl.memEnable && !issCtrl.memWr && issCtrl.regWrite;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            recValid <= 1'b0;
        end else if (!halted) begin
            recValid <= issLoad;     // Cleared by any non-load, the bubble included
        end
    end

    always_ff @(posedge clk) begin
        if (!halted) begin
            recReg <= issDest;
        end
    end

    // Source fields of the raw fetched word
    assign rsHit  = fetchCtrl.usesRs && (fetchWord[10:8] == recReg);
    assign rtHit  = fetchCtrl.usesRt && (fetchWord[7:5] == recReg);
    assign bubble = recValid && (rsHit || rtHit);

endmodule

/* verilog/instrDecoder.sv */
// ==============================
// Opcode decoder producing the control record and destination register
// Used on the issued word and on the raw fetched word
// ==============================

module instrDecoder (
    input  fetchPkg::word_t    instr,
    output fetchPkg::ctrl_t    ctrl,
    output fetchPkg::regAddr_t destAddr
);
    import fetchPkg::*;

    opcode_t opcode;

    assign opcode = instr[15:11];

    always_comb begin
        ctrl = '0;
        case (opcode)
            OP_HALT: begin
                ctrl.halt = 1'b1;
            end
            OP_NOP: begin
                ctrl = '0;                   // Nothing asserted
            end
            OP_J: begin
                ctrl.jumpFlag = 1'b1;
                ctrl.immSel   = IMM_J11;
            end
            OP_JR: begin
                ctrl.jumpFlag = 1'b1;
                ctrl.regJmp   = 1'b1;
                ctrl.immSel   = IMM_B8;
                ctrl.usesRs   = 1'b1;
            end
            OP_JAL: begin
                ctrl.jumpFlag  = 1'b1;
                ctrl.immSel    = IMM_J11;
                ctrl.regWrite  = 1'b1;
                ctrl.linkWrite = 1'b1;
                ctrl.destSel   = DEST_LINK;
            end
            OP_JALR: begin
                ctrl.jumpFlag  = 1'b1;
                ctrl.regJmp    = 1'b1;
                ctrl.immSel    = IMM_B8;
                ctrl.usesRs    = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.linkWrite = 1'b1;
                ctrl.destSel   = DEST_LINK;
            end
            OP_ADDI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSel   = 1'b1;
                ctrl.immSel   = IMM_I5;
                ctrl.usesRs   = 1'b1;
                ctrl.destSel  = DEST_RD_I;
            end
            OP_BEQZ: begin
                ctrl.branchFlag = 1'b1;
                ctrl.immSel     = IMM_B8;
                ctrl.usesRs     = 1'b1;
            end
            OP_ST: begin
                ctrl.memEnable = 1'b1;
                ctrl.memWr     = 1'b1;
                ctrl.aluSel    = 1'b1;
                ctrl.immSel    = IMM_I5;
                ctrl.usesRs    = 1'b1;     // Address base
                ctrl.usesRt    = 1'b1;     // Store data in bits 7:5
            end
            OP_LD: begin
                ctrl.memEnable = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.val2Reg   = 1'b1;
                ctrl.aluSel    = 1'b1;
                ctrl.immSel    = IMM_I5;
                ctrl.usesRs    = 1'b1;
                ctrl.destSel   = DEST_RD_I;
            end
            OP_LBI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSel   = 1'b1;
                ctrl.immSel   = IMM_LBI;
                ctrl.destSel  = DEST_RS;   // Writes, does not read, bits 10:8
            end
            OP_ALU: begin
                ctrl.regWrite = 1'b1;
                ctrl.usesRs   = 1'b1;
                ctrl.usesRt   = 1'b1;
                ctrl.destSel  = DEST_RD_R;
            end
            default: begin
                ctrl.ctrlErr = 1'b1;       // Undefined opcode
            end
        endcase
    end

    // Destination register from fields of the same word
    always_comb begin
        case (ctrl.destSel)
            DEST_RS:   destAddr = instr[10:8];
            DEST_RD_R: destAddr = instr[4:2];
            DEST_LINK: destAddr = 3'd7;
            DEST_RD_I: destAddr = instr[7:5];
        endcase
    end

endmodule

/* verilog/instrMem.sv */
// ==============================
// Word-addressed instruction memory
// Combinational read by pc, clocked write port for program loading
// ==============================

module instrMem #(
    parameter int imemWords = 256
) (
    input  logic                         clk,
    input  logic                         we,
    input  logic [$clog2(imemWords)-1:0] waddr,
    input  fetchPkg::word_t              wdata,
    input  fetchPkg::word_t              raddr,
    output fetchPkg::word_t              rdata
);
    import fetchPkg::*;

    localparam int addrW = $clog2(imemWords);

    word_t            mem [imemWords];
    logic [addrW-1:0] rdIdx;

    // Byte address to word index, wraps at the memory depth
    assign rdIdx = addrW'(raddr[15:1] % imemWords);
    assign rdata = mem[rdIdx];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

endmodule

/* verilog/progCounter.sv */
// ==============================
// Program counter with next-address selection and halt state
// Driven by the issued instruction, redirects and the load-use stall
// ==============================

module progCounter #(
    parameter fetchPkg::word_t resetPc = 16'h0000
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic             stall,
    input  logic             pcSel,
    input  fetchPkg::word_t  brnchAddr,
    input  fetchPkg::word_t  rsData,
    input  fetchPkg::ctrl_t  issCtrl,
    input  fetchPkg::word_t  issInstr,
    output fetchPkg::word_t  pc,
    output logic             halted
);
    import fetchPkg::*;

    pcState_t state, nextState;
    word_t    nextPc;
    word_t    pcPlus2;
    word_t    jmpDisp;
    word_t    regDisp;

    assign pcPlus2 = pc + 16'd2;
    assign jmpDisp = {{5{issInstr[10]}}, issInstr[10:0]};   // J, JAL
    assign regDisp = {{8{issInstr[7]}}, issInstr[7:0]};     // JR, JALR
    assign halted  = (state == PC_HALTED);

    always_comb begin
        nextState = state;
        nextPc    = pcPlus2;
        if (halted || issCtrl.halt) begin
            nextState = PC_HALTED;     // Frozen until reset
            nextPc    = pc;
        end else if (pcSel) begin
            nextPc = brnchAddr;        // Taken branch from a later stage
        end else if (issCtrl.jumpFlag && !issCtrl.regJmp) begin
            nextPc = pcPlus2 + jmpDisp;
        end else if (issCtrl.jumpFlag && issCtrl.regJmp) begin
            nextPc = rsData + regDisp;
        end else if (stall) begin
            nextPc = pc;               // Load-use bubble being issued
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc    <= resetPc;
            state <= PC_RUN;
        end else begin
            pc    <= nextPc;
            state <= nextState;
        end
    end

endmodule
